/* logic/conv_cfg_pkg.sv */
package conv_cfg_pkg;

  // width of one output FIFO word
  parameter int word_width = 128;

  // mode_w8 keeps only the low half of each word
  typedef enum logic {
    mode_w8 = 1'b0,
    mode_w1 = 1'b1
  } store_mode_e;

  typedef enum logic [1:0] {
    reg_base   = 2'd0,
    reg_stride = 2'd1,
    reg_words  = 2'd2,
    reg_mode   = 2'd3
  } reg_addr_e;

  // layer store settings
  typedef struct packed {
    logic [31:0] base_adr;
    logic [31:0] stride;
    logic [15:0] words;
    store_mode_e mode;
  } store_cfg_t;

  typedef struct packed {
    logic [word_width/2-1:0] hi;
    logic [word_width/2-1:0] lo;
  } fifo_halves_t;

  // one FIFO word, seen whole or as two halves
  typedef union packed {
    logic [word_width-1:0] raw;
    fifo_halves_t          half;
  } fifo_word_u;

endpackage

/* logic/conv_out_fifo_bank.sv */
`timescale 1ns/10ps

module conv_out_fifo_bank #(
  parameter int num_fifos  = 4,
  parameter int fifo_depth = 16
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  push,
  input  logic [$clog2(num_fifos)-1:0]          push_sel,
  input  logic [conv_cfg_pkg::word_width-1:0]   push_data,
  input  logic [num_fifos-1:0]                  rds,
  output conv_cfg_pkg::fifo_word_u              rd_word,
  output logic                                  rd_valid
);

  localparam int sel_w = $clog2(num_fifos);
  localparam int ptr_w = $clog2(fifo_depth);

  logic [conv_cfg_pkg::word_width-1:0] mem [num_fifos][fifo_depth];
  logic [ptr_w-1:0] wr_ptr [num_fifos];
  logic [ptr_w-1:0] rd_ptr [num_fifos];
  logic [ptr_w:0]   count  [num_fifos];

  ////////////////////////////////////////////////////////////
  // one circular buffer per array row/column pair
  ////////////////////////////////////////////////////////////
  for (genvar i = 0; i < num_fifos; i++) begin : g_fifo
    logic do_push;
    logic do_pop;

    // full FIFO drops the push
    assign do_push = push && (push_sel == sel_w'(i)) && (count[i] != (ptr_w + 1)'(fifo_depth));
    assign do_pop  = rds[i] && (count[i] != '0);

    always_ff @(posedge clk) begin
      if (reset) begin
        wr_ptr[i] <= '0;
        rd_ptr[i] <= '0;
        count[i]  <= '0;
      end else begin
        if (do_push) begin
          wr_ptr[i] <= wr_ptr[i] + 1'b1;
        end
        if (do_pop) begin
          rd_ptr[i] <= rd_ptr[i] + 1'b1;
        end
        if (do_push && !do_pop) begin
          count[i] <= count[i] + 1'b1;
        end else if (do_pop && !do_push) begin
          count[i] <= count[i] - 1'b1;
        end
      end
    end

    always_ff @(posedge clk) begin
      if (do_push) begin
        mem[i][wr_ptr[i]] <= push_data;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // registered read port
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    for (int i = 0; i < num_fifos; i++) begin
      if (rds[i]) begin
        rd_word.raw <= mem[i][rd_ptr[i]];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= |rds;
    end
  end

endmodule

/* logic/conv_store_packer.sv */
`timescale 1ns/10ps

module conv_store_packer (
  input  logic                     clk,
  input  logic                     reset,
  input  conv_cfg_pkg::store_cfg_t cfg,
  input  logic                     pop_valid,
  input  ddr_store_pkg::pop_req_t  pop,
  input  conv_cfg_pkg::fifo_word_u rd_word,
  input  logic                     rd_valid,
  output logic                     beat_valid,
  output ddr_store_pkg::ddr_beat_t beat,
  output logic                     store_fin
);

  ddr_store_pkg::pop_req_t            pop_q;
  logic [conv_cfg_pkg::word_width/2-1:0] hold_lo;
  logic                               pair;
  logic [31:0]                        beat_adr;
  logic                               cur_pair;
  logic                               complete;
  logic [31:0]                        cur_adr;
  logic                               w8;

  assign w8 = (cfg.mode == conv_cfg_pkg::mode_w8);

  // first word of a block restarts pairing and address
  assign cur_pair = pop_q.first ? 1'b0 : pair;
  assign cur_adr  = pop_q.first ? pop_q.adr : beat_adr;
  assign complete = !w8 || cur_pair;

  ////////////////////////////////////////////////////////////
  // control flags
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      beat_valid <= 1'b0;
      store_fin  <= 1'b0;
      pair       <= 1'b0;
    end else begin
      beat_valid <= rd_valid && complete;
      store_fin  <= rd_valid && complete && pop_q.last_of_tile;
      if (rd_valid) begin
        pair <= w8 && !cur_pair;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // tag delay, half-beat holding, beat assembly
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    // tag lines up with the word read one cycle later
    if (pop_valid) begin
      pop_q <= pop;
    end
    if (rd_valid) begin
      if (!complete) begin
        hold_lo  <= rd_word.half.lo;
        beat_adr <= cur_adr;
      end else begin
        beat.adr <= cur_adr;
        // earlier word of a pair goes to the low half
        beat.data <= w8 ? {rd_word.half.lo, hold_lo} : rd_word.raw;
        beat_adr  <= cur_adr + 32'(ddr_store_pkg::beat_bytes);
      end
    end
  end

endmodule

/* logic/conv_store_regs.sv */
`timescale 1ns/10ps

module conv_store_regs (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cfg_wr,
  input  conv_cfg_pkg::reg_addr_e  cfg_addr,
  input  logic [31:0]              cfg_wdata,
  output conv_cfg_pkg::store_cfg_t cfg
);

  ////////////////////////////////////////////////////////////
  // write-only register map
  ////////////////////////////////////////////////////////////

  // settings apply the cycle after the write
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg <= '0;
    end else if (cfg_wr) begin
      case (cfg_addr)
        conv_cfg_pkg::reg_base: begin
          cfg.base_adr <= cfg_wdata;
        end
        conv_cfg_pkg::reg_stride: begin
          cfg.stride <= cfg_wdata;
        end
        conv_cfg_pkg::reg_words: begin
          // words per FIFO block, must be even in 8-bit mode
          cfg.words <= cfg_wdata[15:0];
        end
        conv_cfg_pkg::reg_mode: begin
          cfg.mode <= conv_cfg_pkg::store_mode_e'(cfg_wdata[0]);
        end
        default: begin
          cfg <= cfg;
        end
      endcase
    end
  end

endmodule

/* logic/conv_store_sequencer.sv */
`timescale 1ns/10ps

module conv_store_sequencer #(
  parameter int num_fifos = 4
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     store_start,
  input  conv_cfg_pkg::store_cfg_t cfg,
  input  logic                     cmd_ready,
  input  logic                     data_ready,
  output logic                     cmd_valid,
  output ddr_store_pkg::ddr_cmd_t  cmd,
  output logic [num_fifos-1:0]     rds,
  output logic                     pop_valid,
  output ddr_store_pkg::pop_req_t  pop
);

  localparam int sel_w = $clog2(num_fifos);

  typedef enum logic [1:0] {
    st_idle,
    st_send_cmd,
    st_pop_blk,
    st_next_blk
  } seq_state_e;

  seq_state_e       state;
  logic [sel_w-1:0] fifo_idx;
  logic [15:0]      pop_cnt;
  logic [31:0]      blk_adr;
  logic             last_fifo;
  logic             last_pop;
  logic [15:0]      cmd_len;

  assign last_fifo = (fifo_idx == sel_w'(num_fifos - 1));
  assign last_pop  = (pop_cnt == cfg.words - 16'd1);

  // length in beats, two words per beat in 8-bit mode
  assign cmd_len = (cfg.mode == conv_cfg_pkg::mode_w1) ? cfg.words : (cfg.words >> 1);

  ////////////////////////////////////////////////////////////
  // command and pop outputs
  ////////////////////////////////////////////////////////////
  assign cmd_valid  = (state == st_send_cmd) && cmd_ready;
  assign cmd.adr    = blk_adr;
  assign cmd.length = cmd_len;

  // one pop per cycle while the data side is ready
  assign pop_valid = (state == st_pop_blk) && data_ready;
  assign rds       = pop_valid ? (num_fifos'(1) << fifo_idx) : '0;

  assign pop.first        = (pop_cnt == 16'd0);
  assign pop.last_of_tile = last_fifo && last_pop;
  assign pop.adr          = blk_adr;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      fifo_idx <= '0;
      pop_cnt  <= '0;
      blk_adr  <= '0;
    end else begin
      case (state)
        st_idle: begin
          // start only counts here
          if (store_start) begin
            state    <= st_send_cmd;
            fifo_idx <= '0;
            blk_adr  <= cfg.base_adr;
          end
        end
        st_send_cmd: begin
          if (cmd_ready) begin
            state   <= st_pop_blk;
            pop_cnt <= '0;
          end
        end
        st_pop_blk: begin
          if (data_ready) begin
            pop_cnt <= pop_cnt + 16'd1;
            if (last_pop) begin
              state <= st_next_blk;
            end
          end
        end
        st_next_blk: begin
          if (last_fifo) begin
            state <= st_idle;
          end else begin
            state    <= st_send_cmd;
            fifo_idx <= fifo_idx + 1'b1;
            blk_adr  <= blk_adr + cfg.stride;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

/* logic/conv_store_top.sv */
`timescale 1ns/10ps

module conv_store_top #(
  parameter int num_fifos  = 4,
  parameter int fifo_depth = 16
) (
  input  logic                                clk,
  input  logic                                reset,
  // config write
  input  logic                                cfg_wr,
  input  conv_cfg_pkg::reg_addr_e             cfg_addr,
  input  logic [31:0]                         cfg_wdata,
  input  logic                                store_start,
  // push port from the array side
  input  logic                                push,
  input  logic [$clog2(num_fifos)-1:0]        push_sel,
  input  logic [conv_cfg_pkg::word_width-1:0] push_data,
  // DDR command side
  input  logic                                cmd_ready,
  output logic                                cmd_valid,
  output ddr_store_pkg::ddr_cmd_t             cmd,
  // DDR data side
  input  logic                                data_ready,
  output logic                                beat_valid,
  output ddr_store_pkg::ddr_beat_t            beat,
  output logic                                store_fin
);

  conv_cfg_pkg::store_cfg_t cfg;
  logic [num_fifos-1:0]     rds;
  logic                     pop_valid;
  ddr_store_pkg::pop_req_t  pop;
  conv_cfg_pkg::fifo_word_u rd_word;
  logic                     rd_valid;

  conv_store_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  conv_out_fifo_bank #(
    .num_fifos  (num_fifos),
    .fifo_depth (fifo_depth)
  ) u_fifo_bank (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .push_sel  (push_sel),
    .push_data (push_data),
    .rds       (rds),
    .rd_word   (rd_word),
    .rd_valid  (rd_valid)
  );

  conv_store_sequencer #(
    .num_fifos (num_fifos)
  ) u_sequencer (
    .clk         (clk),
    .reset       (reset),
    .store_start (store_start),
    .cfg         (cfg),
    .cmd_ready   (cmd_ready),
    .data_ready  (data_ready),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .rds         (rds),
    .pop_valid   (pop_valid),
    .pop         (pop)
  );

  conv_store_packer u_packer (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg),
    .pop_valid  (pop_valid),
    .pop        (pop),
    .rd_word    (rd_word),
    .rd_valid   (rd_valid),
    .beat_valid (beat_valid),
    .beat       (beat),
    .store_fin  (store_fin)
  );

endmodule

/* logic/ddr_store_pkg.sv */
package ddr_store_pkg;

  // one DDR data beat
  parameter int beat_width = 128;
  parameter int beat_bytes = beat_width / 8;

  // write command, length counted in beats
  typedef struct packed {
    logic [31:0] adr;
    logic [15:0] length;
  } ddr_cmd_t;

  typedef struct packed {
    logic [31:0]           adr;
    logic [beat_width-1:0] data;
  } ddr_beat_t;

  // tag that travels with each pop
  typedef struct packed {
    logic        first;
    logic        last_of_tile;
    logic [31:0] adr;
  } pop_req_t;

endpackage

/* test/conv_store_tb_tasks.svh */
// LCG, 32-bit state
function automatic logic [31:0] next_rand();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state;
endfunction

task automatic check_value(input string test_name, input string what,
                           input logic [159:0] expected, input logic [159:0] actual);
  if (expected !== actual) begin
    error_count++;
    $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
  end
endtask

task automatic end_test(input string name, input int errs_before);
  tests_run++;
  if (error_count == errs_before && !timed_out) begin
    $display("%s: ok", name);
  end else begin
    tests_bad++;
    $display("%s: failed with %0d mismatches", name, error_count - errs_before);
  end
endtask

task automatic write_reg(input conv_cfg_pkg::reg_addr_e addr, input logic [31:0] data);
  @(negedge clk);
  cfg_wr    = 1'b1;
  cfg_addr  = addr;
  cfg_wdata = data;
  @(negedge clk);
  cfg_wr = 1'b0;
endtask

task automatic configure(input logic [31:0] base, input logic [31:0] stride,
                         input int words, input conv_cfg_pkg::store_mode_e mode);
  write_reg(conv_cfg_pkg::reg_base, base);
  write_reg(conv_cfg_pkg::reg_stride, stride);
  write_reg(conv_cfg_pkg::reg_words, 32'(words));
  write_reg(conv_cfg_pkg::reg_mode, {31'd0, mode});
endtask

// FIFO 0 first, then the others in index order
task automatic fill_fifos(input int words);
  logic [127:0] w;
  for (int f = 0; f < num_fifos; f++) begin
    for (int k = 0; k < words; k++) begin
      for (int j = 0; j < 4; j++) begin
        w = {w[95:0], next_rand()};
      end
      pushed[f][k] = w;
      @(negedge clk);
      push      = 1'b1;
      push_sel  = 2'(f);
      push_data = w;
    end
  end
  @(negedge clk);
  push = 1'b0;
endtask

////////////////////////////////////////////////////////////
// expected commands and beats
////////////////////////////////////////////////////////////
task automatic build_model(input conv_cfg_pkg::store_mode_e mode, input logic [31:0] base,
                           input logic [31:0] stride, input int words);
  ddr_store_pkg::ddr_cmd_t  c;
  ddr_store_pkg::ddr_beat_t b;
  logic [31:0]              blk;
  exp_cmd_q.delete();
  exp_beat_q.delete();
  for (int f = 0; f < num_fifos; f++) begin
    blk      = base + 32'(f) * stride;
    c.adr    = blk;
    c.length = (mode == conv_cfg_pkg::mode_w1) ? 16'(words) : 16'(words / 2);
    exp_cmd_q.push_back(c);
    for (int j = 0; j < int'(c.length); j++) begin
      b.adr = blk + 32'(j * 16);
      if (mode == conv_cfg_pkg::mode_w1) begin
        b.data = pushed[f][j];
      end else begin
        // earlier word low, later word high, low halves only
        b.data = {pushed[f][2*j+1][63:0], pushed[f][2*j][63:0]};
      end
      exp_beat_q.push_back(b);
    end
  end
endtask

task automatic compare_results(input string name);
  int n;
  check_value(name, "command count", exp_cmd_q.size(), cmd_q.size());
  n = (cmd_q.size() < exp_cmd_q.size()) ? cmd_q.size() : exp_cmd_q.size();
  for (int i = 0; i < n; i++) begin
    check_value(name, $sformatf("command %0d", i), exp_cmd_q[i], cmd_q[i]);
  end
  check_value(name, "beat count", exp_beat_q.size(), beat_q.size());
  n = (beat_q.size() < exp_beat_q.size()) ? beat_q.size() : exp_beat_q.size();
  for (int i = 0; i < n; i++) begin
    check_value(name, $sformatf("beat %0d", i), exp_beat_q[i], beat_q[i]);
  end
  check_value(name, "fin pulses", 1, fin_cnt);
  check_value(name, "fin without beat", 0, fin_alone);
  check_value(name, "fin beat index", exp_beat_q.size(), fin_beat_idx);
  check_value(name, "commands while not ready", 0, cmd_blocked);
endtask

// start, drive ready levels, wait for store_fin
task automatic run_store(input string name, input bit bp, input bit restart);
  int cyc;
  cmd_q.delete();
  beat_q.delete();
  fin_cnt      = 0;
  fin_alone    = 0;
  fin_beat_idx = 0;
  cmd_blocked  = 0;
  @(negedge clk);
  store_start = 1'b1;
  if (bp) begin
    cmd_ready  = 1'b0;
    data_ready = 1'b0;
  end
  cyc = 0;
  while (fin_cnt == 0 && cyc < run_limit) begin
    @(negedge clk);
    // second start lands mid-run
    store_start = restart && (cyc == 9);
    if (bp) begin
      cmd_ready  = (cyc >= 29);
      data_ready = ~data_ready;
    end
    cyc++;
  end
  store_start = 1'b0;
  cmd_ready   = 1'b1;
  data_ready  = 1'b1;
  if (fin_cnt == 0) begin
    timed_out = 1'b1;
    $display("timeout: %s saw no store_fin within %0d cycles", name, run_limit);
  end else begin
    // a few idle cycles to catch stray traffic
    repeat (10) @(negedge clk);
    compare_results(name);
  end
endtask

/* test/conv_store_tb.sv */
`timescale 1ns/10ps

module conv_store_tb;

  localparam int num_fifos  = 4;
  localparam int fifo_depth = 16;
  localparam int run_limit  = 2000;

  logic                     clk;
  logic                     reset;
  logic                     cfg_wr;
  conv_cfg_pkg::reg_addr_e  cfg_addr;
  logic [31:0]              cfg_wdata;
  logic                     store_start;
  logic                     push;
  logic [1:0]               push_sel;
  logic [127:0]             push_data;
  logic                     cmd_ready;
  logic                     cmd_valid;
  ddr_store_pkg::ddr_cmd_t  cmd;
  logic                     data_ready;
  logic                     beat_valid;
  ddr_store_pkg::ddr_beat_t beat;
  logic                     store_fin;

  // observed and expected traffic
  ddr_store_pkg::ddr_cmd_t  cmd_q[$];
  ddr_store_pkg::ddr_cmd_t  exp_cmd_q[$];
  ddr_store_pkg::ddr_beat_t beat_q[$];
  ddr_store_pkg::ddr_beat_t exp_beat_q[$];
  int fin_cnt;
  int fin_alone;
  int fin_beat_idx;
  int cmd_blocked;
  int error_count;
  int tests_run;
  int tests_bad;
  bit timed_out;
  logic [31:0]  lcg_state;
  logic [127:0] pushed [num_fifos][fifo_depth];

  `include "conv_store_tb_tasks.svh"

  always #4 clk = ~clk;

  conv_store_top #(
    .num_fifos  (num_fifos),
    .fifo_depth (fifo_depth)
  ) uut (
    .clk         (clk),
    .reset       (reset),
    .cfg_wr      (cfg_wr),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .store_start (store_start),
    .push        (push),
    .push_sel    (push_sel),
    .push_data   (push_data),
    .cmd_ready   (cmd_ready),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .data_ready  (data_ready),
    .beat_valid  (beat_valid),
    .beat        (beat),
    .store_fin   (store_fin)
  );

  ////////////////////////////////////////////////////////////
  // output monitors
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (!reset) begin
      if (cmd_valid) begin
        cmd_q.push_back(cmd);
        if (!cmd_ready) begin
          cmd_blocked++;
        end
      end
      if (beat_valid) begin
        beat_q.push_back(beat);
      end
      // fin must land on the last beat
      if (store_fin) begin
        fin_cnt++;
        fin_beat_idx = beat_q.size();
        if (!beat_valid) begin
          fin_alone++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // test list
  ////////////////////////////////////////////////////////////
  task automatic test_idle();
    int errs;
    errs = error_count;
    cmd_q.delete();
    beat_q.delete();
    fin_cnt = 0;
    repeat (20) @(negedge clk);
    check_value("idle", "commands", 0, cmd_q.size());
    check_value("idle", "beats", 0, beat_q.size());
    check_value("idle", "fin pulses", 0, fin_cnt);
    end_test("idle", errs);
  endtask

  task automatic test_store(input string name, input conv_cfg_pkg::store_mode_e mode,
                            input logic [31:0] base, input logic [31:0] stride,
                            input int words, input bit bp, input bit restart);
    int errs;
    errs = error_count;
    configure(base, stride, words, mode);
    fill_fifos(words);
    build_model(mode, base, stride, words);
    run_store(name, bp, restart);
    end_test(name, errs);
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    cfg_wr      = 1'b0;
    cfg_addr    = conv_cfg_pkg::reg_base;
    cfg_wdata   = '0;
    store_start = 1'b0;
    push        = 1'b0;
    push_sel    = '0;
    push_data   = '0;
    cmd_ready   = 1'b1;
    data_ready  = 1'b1;
    error_count = 0;
    tests_run   = 0;
    tests_bad   = 0;
    timed_out   = 1'b0;
    lcg_state   = 32'd41275;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    test_idle();
    if (!timed_out) begin
      test_store("w1_blocks", conv_cfg_pkg::mode_w1, 32'h1000_0000, 32'h400, 4, 0, 0);
    end
    if (!timed_out) begin
      test_store("w8_pairs", conv_cfg_pkg::mode_w8, 32'h2000_0100, 32'h200, 6, 0, 0);
    end
    if (!timed_out) begin
      test_store("backpressure", conv_cfg_pkg::mode_w8, 32'h3000_0000, 32'h1000, 8, 1, 0);
    end
    if (!timed_out) begin
      test_store("fin_once", conv_cfg_pkg::mode_w1, 32'h0400_0040, 32'h100, 4, 0, 1);
    end

    $display("summary: %0d tests run, %0d with errors, %0d mismatches",
             tests_run, tests_bad, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
logic/conv_cfg_pkg.sv
logic/ddr_store_pkg.sv
logic/conv_out_fifo_bank.sv
logic/conv_store_regs.sv
logic/conv_store_sequencer.sv
logic/conv_store_packer.sv
logic/conv_store_top.sv
+incdir+test
test/conv_store_tb.sv
